//--- test/noncomp_stim.txt
# op rnd op_mod operand_a operand_b : exp_result exp_status exp_ext exp_class_mask
# All fields hex; op 0 SGNJ 1 MINMAX 2 CMP 3 CLASSIFY, status NV is 10
0 0 0 3f800000 bf800000 bf800000 00 1 040
0 1 0 3f800000 bf800000 3f800000 00 1 040
0 2 0 bf800000 bf800000 3f800000 00 1 002
0 0 1 00000000 80000000 80000000 00 1 010
0 1 1 80000000 80000000 00000000 00 0 008
0 2 1 7fc00000 ff800000 ffc00000 00 1 200
0 0 0 7f800001 3f800000 7f800001 00 1 100
1 0 0 3f800000 40000000 3f800000 00 1 040
1 1 0 3f800000 40000000 40000000 00 1 040
1 0 0 bf800000 c0000000 c0000000 00 1 002
1 1 0 bf800000 3f800000 3f800000 00 1 002
1 0 0 80000000 00000000 80000000 00 1 008
1 1 0 80000000 00000000 00000000 00 1 008
1 0 0 7fc00000 3f800000 3f800000 00 1 200
1 1 0 c0000000 7fc00000 c0000000 00 1 002
1 0 0 7fc00000 ffc00000 7fc00000 00 1 200
1 1 0 7f800001 40000000 40000000 10 1 100
1 0 0 7f800001 7fc00000 7fc00000 10 1 100
1 1 0 ff800000 7f800000 7f800000 00 1 001
2 0 0 3f800000 40000000 00000001 00 0 040
2 0 0 40000000 3f800000 00000000 00 0 040
2 0 0 3f800000 3f800000 00000001 00 0 040
2 1 0 3f800000 3f800000 00000000 00 0 040
2 1 0 bf800000 3f800000 00000001 00 0 002
2 2 0 80000000 00000000 00000001 00 0 008
2 2 1 3f800000 3f800000 00000000 00 0 040
2 1 1 3f800000 40000000 00000000 00 0 040
2 0 0 7fc00000 3f800000 00000000 10 0 200
2 2 0 7fc00000 7fc00000 00000000 00 0 200
2 2 1 3f800000 7fc00000 00000001 00 0 040
2 2 1 7f800001 3f800000 00000000 10 0 100
2 1 0 c0000000 bf800000 00000001 00 0 002
3 0 0 ff800000 00000000 00000000 00 0 001
3 0 0 bf800000 00000000 00000000 00 0 002
3 0 0 80000001 00000000 00000000 00 0 004
3 0 0 80000000 00000000 00000000 00 0 008
3 0 0 00000000 00000000 00000000 00 0 010
3 0 0 00400000 00000000 00000000 00 0 020
3 0 0 3f800000 00000000 00000000 00 0 040
3 0 0 7f800000 00000000 00000000 00 0 080
3 0 0 7f800001 00000000 00000000 00 0 100
3 0 0 7fc00000 00000000 00000000 00 0 200

//--- list.f
logic/fpu_nc_pkg.sv
logic/fp_operand_classifier.sv
logic/nc_pipe_stages.sv
logic/fp_minmax_compare.sv
logic/fp_sign_class.sv
logic/fpu_noncomp.sv
test/tb_fpu_noncomp.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project root"
  exit 1
fi

verilator --binary --timing --assert -f list.f --top-module tb_fpu_noncomp -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/sim_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

# Pass only when the testbench printed its pass line
if echo "$sim_out" | grep -qx "sim passed"; then
  exit 0
fi
exit 1

//--- test/tb_fpu_noncomp.sv
`timescale 1ns/1ps

module tb_fpu_noncomp;

  import fpu_nc_pkg::*;

  localparam int MAX_VEC = 64;
  // Columns of one stimulus line
  localparam int COL_OP     = 0;
  localparam int COL_RND    = 1;
  localparam int COL_MOD    = 2;
  localparam int COL_A      = 3;
  localparam int COL_B      = 4;
  localparam int COL_RES    = 5;
  localparam int COL_STATUS = 6;
  localparam int COL_EXT    = 7;
  localparam int COL_CLASS  = 8;

  logic                clk_i = 1'b0;
  logic                rst_n_i;
  fp_t                 operand_a_i;
  fp_t                 operand_b_i;
  op_e                 op_i;
  roundmode_e          rnd_mode_i;
  logic                op_mod_i;
  logic [TAG_BITS-1:0] tag_i;
  logic                in_valid_i;
  logic                in_ready_o;
  fp_t                 result_o;
  status_t             status_o;
  logic                extension_bit_o;
  classmask_e          class_mask_o;
  logic                is_class_o;
  logic [TAG_BITS-1:0] tag_o;
  logic                out_valid_o;
  logic                out_ready_i;
  logic                busy_o;

  logic [31:0] vectors [0:MAX_VEC-1][0:8];
  int          num_vec = 0;
  int          err_count = 0;
  int          checked = 0;
  logic        load_done = 1'b0;
  logic [31:0] rng_state;
  logic [31:0] pick;
  // Indices of accepted vectors in arrival order
  int          exp_q [$];
  int          drv_idx;

  fpu_noncomp #(
    .NUM_INP_REGS (1),
    .NUM_OUT_REGS (1)
  ) fpu_noncomp_i (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .operand_a_i     (operand_a_i),
    .operand_b_i     (operand_b_i),
    .op_i            (op_i),
    .rnd_mode_i      (rnd_mode_i),
    .op_mod_i        (op_mod_i),
    .tag_i           (tag_i),
    .in_valid_i      (in_valid_i),
    .in_ready_o      (in_ready_o),
    .result_o        (result_o),
    .status_o        (status_o),
    .extension_bit_o (extension_bit_o),
    .class_mask_o    (class_mask_o),
    .is_class_o      (is_class_o),
    .tag_o           (tag_o),
    .out_valid_o     (out_valid_o),
    .out_ready_i     (out_ready_i),
    .busy_o          (busy_o)
  );

  // 8 ns period
  always #4 clk_i = ~clk_i;

  // --------------------
  // Helpers
  // --------------------
  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic check_field(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val) else begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp_val, act_val);
      err_count++;
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    rc;
    string line;
    fd = $fopen("test/noncomp_stim.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file test/noncomp_stim.txt could not be opened");
      err_count++;
    end else begin
      while (!$feof(fd) && num_vec < MAX_VEC) begin
        rc = $fgets(line, fd);
        // Skip column notes and blank lines
        if (rc > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
          rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                       vectors[num_vec][0], vectors[num_vec][1], vectors[num_vec][2],
                       vectors[num_vec][3], vectors[num_vec][4], vectors[num_vec][5],
                       vectors[num_vec][6], vectors[num_vec][7], vectors[num_vec][8]);
          if (rc == 9) begin
            num_vec++;
          end else begin
            $display("Stimulus line after vector %0d has the wrong number of fields", num_vec);
            err_count++;
          end
        end
      end
      $fclose(fd);
    end
    if (num_vec == 0) begin
      $display("No vectors were read from the stimulus file");
      err_count++;
    end
    load_done = 1'b1;
  endtask

  task automatic drive_vector(input int idx);
    operand_a_i = fp_t'(vectors[idx][COL_A]);
    operand_b_i = fp_t'(vectors[idx][COL_B]);
    op_i        = op_e'(vectors[idx][COL_OP][1:0]);
    rnd_mode_i  = roundmode_e'(vectors[idx][COL_RND][2:0]);
    op_mod_i    = vectors[idx][COL_MOD][0];
    // Tag is the vector index modulo 16
    tag_i       = idx[3:0];
    in_valid_i  = 1'b1;
  endtask

  task automatic check_output();
    int idx;
    if (exp_q.size() == 0) begin
      $display("Output transfer at %0t with no vector waiting for it", $time);
      err_count++;
    end else begin
      idx = exp_q.pop_front();
      check_field("result_o", vectors[idx][COL_RES], result_o);
      check_field("status_o", vectors[idx][COL_STATUS], {27'd0, status_o});
      check_field("extension_bit_o", vectors[idx][COL_EXT], {31'd0, extension_bit_o});
      check_field("class_mask_o", vectors[idx][COL_CLASS], {22'd0, class_mask_o});
      // Only the classify op raises is_class
      check_field("is_class_o", {31'd0, vectors[idx][COL_OP] == 32'd3}, {31'd0, is_class_o});
      check_field("tag_o", {28'd0, idx[3:0]}, {28'd0, tag_o});
      checked++;
    end
  endtask

  // --------------------
  // Back-pressure
  // --------------------
  // Ready high on roughly 70 of 100 cycles
  initial begin
    out_ready_i = 1'b0;
    rng_state   = 32'd54;
    forever begin
      @(negedge clk_i);
      rng_state   = next_random(rng_state);
      pick        = {17'd0, rng_state[30:16]};
      out_ready_i = (pick % 32'd100) < 32'd70;
    end
  end

  // --------------------
  // Driver
  // --------------------
  initial begin
    rst_n_i     = 1'b0;
    in_valid_i  = 1'b0;
    operand_a_i = '0;
    operand_b_i = '0;
    op_i        = SGNJ;
    rnd_mode_i  = RNE;
    op_mod_i    = 1'b0;
    tag_i       = '0;
    load_vectors();
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    #1;
    // Pipe must come out of reset empty
    assert (!out_valid_o && !busy_o) else begin
      $display("Output valid or busy is high right after reset");
      err_count++;
    end
    assert (in_ready_o) else begin
      $display("Input ready is low right after reset");
      err_count++;
    end
    @(negedge clk_i);
    drv_idx = 0;
    while (drv_idx < num_vec) begin
      drive_vector(drv_idx);
      #1;
      // Inputs hold until the next falling edge, so this predicts the transfer
      if (in_ready_o) begin
        exp_q.push_back(drv_idx);
        drv_idx++;
      end
      @(negedge clk_i);
    end
    in_valid_i = 1'b0;
    while (checked < num_vec) @(negedge clk_i);
    @(negedge clk_i);
    #1;
    assert (!out_valid_o && !busy_o) else begin
      $display("Output valid or busy is still high after the final drain");
      err_count++;
    end
    $display("Errors: %0d, vectors checked: %0d of %0d", err_count, checked, num_vec);
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // --------------------
  // Monitor
  // --------------------
  always @(negedge clk_i) begin
    #2;
    // A waiting result is an item in flight
    if (rst_n_i && out_valid_o) begin
      assert (busy_o) else begin
        $display("Busy is low at %0t while a result is waiting at the output", $time);
        err_count++;
      end
    end
    if (rst_n_i && out_valid_o && out_ready_i) begin
      check_output();
    end
  end

  // Watchdog sized from the vector count
  initial begin
    wait (load_done);
    repeat (num_vec * 20 + 200) @(posedge clk_i);
    $display("Timeout: the run did not finish, %0d of %0d results seen", checked, num_vec);
    $display("Errors: %0d, vectors checked: %0d of %0d", err_count, checked, num_vec);
    $display("sim failed");
    $finish;
  end

endmodule

//--- logic/fpu_noncomp.sv
`timescale 1ns/1ps

module fpu_noncomp #(
  parameter int NUM_INP_REGS = 1,
  parameter int NUM_OUT_REGS = 1
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  fpu_nc_pkg::fp_t                 operand_a_i,
  input  fpu_nc_pkg::fp_t                 operand_b_i,
  input  fpu_nc_pkg::op_e                 op_i,
  input  fpu_nc_pkg::roundmode_e          rnd_mode_i,
  input  logic                            op_mod_i,
  input  logic [fpu_nc_pkg::TAG_BITS-1:0] tag_i,
  input  logic                            in_valid_i,
  output logic                            in_ready_o,
  output fpu_nc_pkg::fp_t                 result_o,
  output fpu_nc_pkg::status_t             status_o,
  output logic                            extension_bit_o,
  output fpu_nc_pkg::classmask_e          class_mask_o,
  output logic                            is_class_o,
  output logic [fpu_nc_pkg::TAG_BITS-1:0] tag_o,
  output logic                            out_valid_o,
  input  logic                            out_ready_i,
  output logic                            busy_o
);

  import fpu_nc_pkg::*;

  nc_in_payload_t  in_payload;
  nc_in_payload_t  inp_q;
  nc_out_payload_t out_payload;
  nc_out_payload_t out_q;
  logic            inp_valid;
  logic            inp_ready;
  logic            inp_busy;
  logic            out_busy;
  fp_info_t        info_a;
  fp_info_t        info_b;
  fp_t             sgnj_result;
  fp_t             minmax_result;
  fp_t             cmp_result;
  status_t         minmax_status;
  status_t         cmp_status;
  classmask_e      class_mask;

  // --------------------
  // Input stages
  // --------------------
  assign in_payload.operand_a = operand_a_i;
  assign in_payload.operand_b = operand_b_i;
  assign in_payload.op        = op_i;
  assign in_payload.rnd_mode  = rnd_mode_i;
  assign in_payload.op_mod    = op_mod_i;
  assign in_payload.tag       = tag_i;

  nc_pipe_stages #(
    .NUM_STAGES (NUM_INP_REGS),
    .payload_t  (nc_in_payload_t)
  ) inp_stages_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (in_valid_i),
    .ready_o   (in_ready_o),
    .payload_i (in_payload),
    .valid_o   (inp_valid),
    .ready_i   (inp_ready),
    .payload_o (inp_q),
    .busy_o    (inp_busy)
  );

  // Operand classes feed both units
  fp_operand_classifier class_a_i (.operand_i(inp_q.operand_a), .info_o(info_a));
  fp_operand_classifier class_b_i (.operand_i(inp_q.operand_b), .info_o(info_b));

  fp_minmax_compare minmax_cmp_i (
    .operand_a_i     (inp_q.operand_a),
    .operand_b_i     (inp_q.operand_b),
    .info_a_i        (info_a),
    .info_b_i        (info_b),
    .rnd_mode_i      (inp_q.rnd_mode),
    .op_mod_i        (inp_q.op_mod),
    .minmax_result_o (minmax_result),
    .minmax_status_o (minmax_status),
    .cmp_result_o    (cmp_result),
    .cmp_status_o    (cmp_status)
  );

  fp_sign_class sign_class_i (
    .operand_a_i   (inp_q.operand_a),
    .operand_b_i   (inp_q.operand_b),
    .info_a_i      (info_a),
    .rnd_mode_i    (inp_q.rnd_mode),
    .sgnj_result_o (sgnj_result),
    .class_mask_o  (class_mask)
  );

  // --------------------
  // Result selection
  // --------------------
  always_comb begin
    out_payload.result        = '0;
    out_payload.status        = '0;
    out_payload.extension_bit = 1'b0;
    case (inp_q.op)
      // Sign injection never raises flags
      SGNJ: begin
        out_payload.result        = sgnj_result;
        out_payload.extension_bit = inp_q.op_mod ? sgnj_result.sign : 1'b1;
      end
      MINMAX: begin
        out_payload.result        = minmax_result;
        out_payload.status        = minmax_status;
        out_payload.extension_bit = 1'b1;
      end
      CMP: begin
        out_payload.result = cmp_result;
        out_payload.status = cmp_status;
      end
      // Classify answers through the class mask only
      default: out_payload.result = '0;
    endcase
  end

  assign out_payload.class_mask = class_mask;
  assign out_payload.is_class   = (inp_q.op == CLASSIFY);
  assign out_payload.tag        = inp_q.tag;

  // --------------------
  // Output stages
  // --------------------
  nc_pipe_stages #(
    .NUM_STAGES (NUM_OUT_REGS),
    .payload_t  (nc_out_payload_t)
  ) out_stages_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .valid_i   (inp_valid),
    .ready_o   (inp_ready),
    .payload_i (out_payload),
    .valid_o   (out_valid_o),
    .ready_i   (out_ready_i),
    .payload_o (out_q),
    .busy_o    (out_busy)
  );

  assign result_o        = out_q.result;
  assign status_o        = out_q.status;
  assign extension_bit_o = out_q.extension_bit;
  assign class_mask_o    = out_q.class_mask;
  assign is_class_o      = out_q.is_class;
  assign tag_o           = out_q.tag;
  // Anything still held in either chain
  assign busy_o          = inp_busy | out_busy;

endmodule

//--- logic/fp_sign_class.sv
`timescale 1ns/1ps

module fp_sign_class (
  input  fpu_nc_pkg::fp_t        operand_a_i,
  input  fpu_nc_pkg::fp_t        operand_b_i,
  input  fpu_nc_pkg::fp_info_t   info_a_i,
  input  fpu_nc_pkg::roundmode_e rnd_mode_i,
  output fpu_nc_pkg::fp_t        sgnj_result_o,
  output fpu_nc_pkg::classmask_e class_mask_o
);

  import fpu_nc_pkg::*;

  // --------------------
  // Sign injection
  // --------------------
  // Magnitude always from a, only the sign changes
  always_comb begin
    sgnj_result_o = operand_a_i;
    case (rnd_mode_i)
      RNE:     sgnj_result_o.sign = operand_b_i.sign;
      RTZ:     sgnj_result_o.sign = ~operand_b_i.sign;
      RDN:     sgnj_result_o.sign = operand_a_i.sign ^ operand_b_i.sign;
      // Unused codes pass a through
      default: sgnj_result_o = operand_a_i;
    endcase
  end

  // --------------------
  // Classification
  // --------------------
  // Class of operand a only
  always_comb begin
    if (info_a_i.is_normal) begin
      class_mask_o = operand_a_i.sign ? NEGNORM : POSNORM;
    end else if (info_a_i.is_subnormal) begin
      class_mask_o = operand_a_i.sign ? NEGSUBNORM : POSSUBNORM;
    end else if (info_a_i.is_zero) begin
      class_mask_o = operand_a_i.sign ? NEGZERO : POSZERO;
    end else if (info_a_i.is_inf) begin
      class_mask_o = operand_a_i.sign ? NEGINF : POSINF;
    end else if (info_a_i.is_signalling) begin
      // NaN sign is ignored
      class_mask_o = SNAN;
    end else begin
      class_mask_o = QNAN;
    end
  end

endmodule

//--- logic/fp_minmax_compare.sv
`timescale 1ns/1ps

module fp_minmax_compare (
  input  fpu_nc_pkg::fp_t        operand_a_i,
  input  fpu_nc_pkg::fp_t        operand_b_i,
  input  fpu_nc_pkg::fp_info_t   info_a_i,
  input  fpu_nc_pkg::fp_info_t   info_b_i,
  input  fpu_nc_pkg::roundmode_e rnd_mode_i,
  input  logic                   op_mod_i,
  output fpu_nc_pkg::fp_t        minmax_result_o,
  output fpu_nc_pkg::status_t    minmax_status_o,
  output fpu_nc_pkg::fp_t        cmp_result_o,
  output fpu_nc_pkg::status_t    cmp_status_o
);

  import fpu_nc_pkg::*;

  logic [FP_WIDTH-1:0] bits_a;
  logic [FP_WIDTH-1:0] bits_b;
  logic                any_nan;
  logic                any_snan;
  logic                operands_equal;
  logic                a_smaller;
  logic                cmp_bit;

  assign bits_a = operand_a_i;
  assign bits_b = operand_b_i;

  // NaN reductions over both operands
  assign any_nan  = info_a_i.is_nan | info_b_i.is_nan;
  assign any_snan = info_a_i.is_signalling | info_b_i.is_signalling;

  // --------------------
  // Ordering
  // --------------------
  // +0 and -0 count as equal
  assign operands_equal = (bits_a == bits_b) | (info_a_i.is_zero & info_b_i.is_zero);
  // Sign-magnitude word, unsigned order flips once a sign is set
  assign a_smaller = (bits_a < bits_b) ^ (operand_a_i.sign | operand_b_i.sign);

  // --------------------
  // Min / max
  // --------------------
  always_comb begin
    minmax_status_o    = '0;
    // Quiet comparison, only sNaN is invalid
    minmax_status_o.NV = any_snan;
    if (info_a_i.is_nan && info_b_i.is_nan) begin
      minmax_result_o = CANON_QNAN;
    end else if (info_a_i.is_nan) begin
      minmax_result_o = operand_b_i;
    end else if (info_b_i.is_nan) begin
      minmax_result_o = operand_a_i;
    end else begin
      case (rnd_mode_i)
        RNE:     minmax_result_o = a_smaller ? operand_a_i : operand_b_i;
        RTZ:     minmax_result_o = a_smaller ? operand_b_i : operand_a_i;
        default: minmax_result_o = '0;
      endcase
    end
  end

  // --------------------
  // Compare
  // --------------------
  always_comb begin
    cmp_bit      = 1'b0;
    cmp_status_o = '0;
    // sNaN always false and invalid
    if (any_snan) begin
      cmp_status_o.NV = 1'b1;
    end else begin
      case (rnd_mode_i)
        // LE and LT signal on any NaN
        RNE: begin
          if (any_nan) cmp_status_o.NV = 1'b1;
          else         cmp_bit = (a_smaller | operands_equal) ^ op_mod_i;
        end
        RTZ: begin
          if (any_nan) cmp_status_o.NV = 1'b1;
          else         cmp_bit = (a_smaller & ~operands_equal) ^ op_mod_i;
        end
        // EQ is quiet, NaN never equal
        RDN: begin
          if (any_nan) cmp_bit = op_mod_i;
          else         cmp_bit = operands_equal ^ op_mod_i;
        end
        default: cmp_bit = 1'b0;
      endcase
    end
  end

  // Boolean lands in bit 0
  assign cmp_result_o = fp_t'({{(FP_WIDTH-1){1'b0}}, cmp_bit});

endmodule

//--- logic/nc_pipe_stages.sv
`timescale 1ns/1ps

module nc_pipe_stages #(
  parameter int  NUM_STAGES = 1,
  parameter type payload_t  = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t payload_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t payload_o,
  output logic     busy_o
);

  // Index i holds the item after i register stages
  payload_t stage_data [0:NUM_STAGES];
  logic [0:NUM_STAGES] stage_valid;
  logic [0:NUM_STAGES] stage_ready;

  // Entry point of the chain
  assign stage_data[0]  = payload_i;
  assign stage_valid[0] = valid_i;

  // --------------------
  // Ready chain
  // --------------------
  // A stage advances if the next one moves on or only holds a bubble
  always_comb begin
    stage_ready[NUM_STAGES] = ready_i;
    for (int i = NUM_STAGES - 1; i >= 0; i--) begin
      stage_ready[i] = stage_ready[i+1] | ~stage_valid[i+1];
    end
  end

  for (genvar i = 0; i < NUM_STAGES; i++) begin : gen_stage
    logic load;

    // Capture payload only for a real item
    assign load = stage_ready[i] & stage_valid[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load) begin
        stage_data[i+1] <= stage_data[i];
      end
    end
  end

  // Exit point of the chain
  assign ready_o   = stage_ready[0];
  assign valid_o   = stage_valid[NUM_STAGES];
  assign payload_o = stage_data[NUM_STAGES];

  // Items in flight, none without registers
  if (NUM_STAGES == 0) begin : gen_no_busy
    assign busy_o = 1'b0;
  end else begin : gen_busy
    assign busy_o = |stage_valid[1:NUM_STAGES];
  end

endmodule

//--- logic/fp_operand_classifier.sv
`timescale 1ns/1ps

module fp_operand_classifier (
  input  fpu_nc_pkg::fp_t      operand_i,
  output fpu_nc_pkg::fp_info_t info_o
);

  logic exp_ones;
  logic exp_zero;
  logic man_zero;

  // Field checks on the raw word
  assign exp_ones = &operand_i.exponent;
  assign exp_zero = ~|operand_i.exponent;
  assign man_zero = ~|operand_i.mantissa;

  // --------------------
  // Class flags
  // --------------------
  // Biased exponent neither zero nor all ones
  assign info_o.is_normal    = ~exp_ones & ~exp_zero;
  // Zero exponent splits on the mantissa
  assign info_o.is_subnormal = exp_zero & ~man_zero;
  assign info_o.is_zero      = exp_zero & man_zero;
  // All-ones exponent is inf or NaN
  assign info_o.is_inf       = exp_ones & man_zero;
  assign info_o.is_nan       = exp_ones & ~man_zero;
  // Quiet bit clear means signalling
  assign info_o.is_signalling = exp_ones & ~man_zero & ~operand_i.mantissa[22];

endmodule

//--- logic/fpu_nc_pkg.sv
package fpu_nc_pkg;

  // --------------------
  // Binary32 format
  // --------------------
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned MAN_BITS = 23;
  localparam int unsigned FP_WIDTH = 1 + EXP_BITS + MAN_BITS;
  // Transaction tag carried next to each operation
  localparam int unsigned TAG_BITS = 4;

  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Class flags of a single operand
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // --------------------
  // Operation encoding
  // --------------------
  typedef enum logic [1:0] {
    SGNJ     = 2'd0,
    MINMAX   = 2'd1,
    CMP      = 2'd2,
    CLASSIFY = 2'd3
  } op_e;

  // Sub-operation select, codes 3 to 7 are unused
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010
  } roundmode_e;

  typedef struct packed {
    logic NV;
    logic DZ;
    logic OF;
    logic UF;
    logic NX;
  } status_t;

  // One-hot class, bit 0 upward
  typedef enum logic [9:0] {
    NEGINF     = 10'b00_0000_0001,
    NEGNORM    = 10'b00_0000_0010,
    NEGSUBNORM = 10'b00_0000_0100,
    NEGZERO    = 10'b00_0000_1000,
    POSZERO    = 10'b00_0001_0000,
    POSSUBNORM = 10'b00_0010_0000,
    POSNORM    = 10'b00_0100_0000,
    POSINF     = 10'b00_1000_0000,
    SNAN       = 10'b01_0000_0000,
    QNAN       = 10'b10_0000_0000
  } classmask_e;

  // Positive quiet NaN with only the mantissa MSB set
  localparam fp_t CANON_QNAN = '{sign: 1'b0, exponent: '1, mantissa: 23'h40_0000};

  // --------------------
  // Pipeline payloads
  // --------------------
  typedef struct packed {
    fp_t                 operand_a;
    fp_t                 operand_b;
    op_e                 op;
    roundmode_e          rnd_mode;
    logic                op_mod;
    logic [TAG_BITS-1:0] tag;
  } nc_in_payload_t;

  typedef struct packed {
    fp_t                 result;
    status_t             status;
    logic                extension_bit;
    classmask_e          class_mask;
    logic                is_class;
    logic [TAG_BITS-1:0] tag;
  } nc_out_payload_t;

endpackage
